// ==== src/regFilePkg.sv ====
// ==========================================================================
// register file package
// constants, instruction views and stage payload structs
// ==========================================================================
`default_nettype none

package regFilePkg;

  // word and register count are fixed by the instruction format
  localparam int wordWidth = 32;
  localparam int regCount = 16;
  localparam int pcIndex = 15;
  localparam int pcStep = 4;
  // class code in bits 27..25 that marks a branch
  localparam logic [2:0] branchClass = 3'b101;

  typedef logic [wordWidth-1:0] word_t;
  typedef logic [$clog2(regCount)-1:0] regAddr_t;

  // data-processing view of a fetched word
  typedef struct packed {
    logic [3:0] cond;
    logic [2:0] instrClass;
    logic [3:0] opcode;
    logic setFlags;
    regAddr_t rn;
    regAddr_t rd;
    // low nibble is rm
    logic [11:0] shifterOp;
  } dataProcFields_t;

  // branch view of the same word
  typedef struct packed {
    logic [3:0] cond;
    logic [2:0] instrClass;
    logic link;
    logic [23:0] offset;
  } branchFields_t;

  // one fetched word, read both ways
  typedef union packed {
    word_t raw;
    dataProcFields_t dp;
    branchFields_t br;
  } instrWord_u;

  // IF/ID payload
  typedef struct packed {
    logic [3:0] cond;
    logic [3:0] opcode;
    logic isBranch;
    logic link;
    regAddr_t rn;
    regAddr_t rm;
    regAddr_t rd;
    word_t imm;
  } decodedInstr_t;

  // external write port, no handshake
  typedef struct packed {
    logic en;
    regAddr_t addr;
    word_t data;
  } regWrite_t;

  // ID/EX payload offered to the outside
  typedef struct packed {
    logic [3:0] cond;
    logic [3:0] opcode;
    logic isBranch;
    logic link;
    regAddr_t rd;
    word_t opA;
    word_t opB;
    word_t opC;
    word_t imm;
  } operandBundle_t;

endpackage

`default_nettype wire

// ==== src/instrDecoder.sv ====
// ==========================================================================
// IF/ID stage
// four-phase instruction acceptor, field decode and PC step strobe
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
  input  logic clk,
  input  logic clr,
  input  logic instrReq,
  input  regFilePkg::instrWord_u instrWord,
  output logic instrAck,
  input  logic take,
  output logic full,
  output regFilePkg::decodedInstr_t decoded,
  output logic pcAdvance
);

  import regFilePkg::*;

  decodedInstr_t nextItem;

  // new request, stage empty, previous exchange closed
  assign pcAdvance = instrReq && !full && !instrAck;

  // split the incoming word, before capture
  always_comb
  begin
    nextItem = '0;
    nextItem.cond = instrWord.dp.cond;
    if (instrWord.br.instrClass == branchClass)
    begin
      nextItem.isBranch = 1'b1;
      nextItem.link = instrWord.br.link;
      // branch operand A is the PC
      nextItem.rn = regAddr_t'(pcIndex);
      // word offset to byte offset, sign kept
      nextItem.imm = {{6{instrWord.br.offset[23]}}, instrWord.br.offset, 2'b00};
    end
    else
    begin
      nextItem.opcode = instrWord.dp.opcode;
      nextItem.rn = instrWord.dp.rn;
      nextItem.rm = instrWord.dp.shifterOp[3:0];
      nextItem.rd = instrWord.dp.rd;
      // shifter field passed on unsigned
      nextItem.imm = word_t'(instrWord.dp.shifterOp);
    end
  end

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      instrAck <= 1'b0;
      full <= 1'b0;
      decoded <= '0;
    end
    else if (pcAdvance)
    begin
      // capture and acknowledge in one step
      decoded <= nextItem;
      full <= 1'b1;
      instrAck <= 1'b1;
    end
    else
    begin
      // issue stage pulled the item
      if (take)
        full <= 1'b0;
      // requester let go, close the exchange
      if (instrAck && !instrReq)
        instrAck <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/registerFile.sv ====
// ==========================================================================
// register file
// sixteen words, one write port, three read ports, R15 doubles as PC
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic clk,
  input  logic clr,
  input  regFilePkg::regWrite_t regWrite,
  input  logic pcAdvance,
  input  regFilePkg::regAddr_t readSelA,
  input  regFilePkg::regAddr_t readSelB,
  input  regFilePkg::regAddr_t readSelC,
  output regFilePkg::word_t readA,
  output regFilePkg::word_t readB,
  output regFilePkg::word_t readC
);

  import regFilePkg::*;

  word_t regs [regCount];
  logic [regCount-1:0] writeSel;

  // one-hot write decode
  always_comb
  begin
    writeSel = '0;
    if (regWrite.en)
      writeSel[regWrite.addr] = 1'b1;
  end

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      for (int i = 0; i < regCount; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < regCount; i++)
      begin
        if (i == pcIndex)
        begin
          // explicit write beats the fetch step
          if (writeSel[i])
            regs[i] <= regWrite.data;
          else if (pcAdvance)
            regs[i] <= regs[i] + word_t'(pcStep);
        end
        else if (writeSel[i])
        begin
          regs[i] <= regWrite.data;
        end
      end
    end
  end

  // 16:1 select, one per read port
  function automatic word_t readMux(input regAddr_t sel, input word_t bank [regCount]);
    word_t result;
    result = '0;
    for (int i = 0; i < regCount; i++)
    begin
      if (sel == regAddr_t'(i))
        result = bank[i];
    end
    return result;
  endfunction

  // reads see writes from the previous edge
  assign readA = readMux(readSelA, regs);
  assign readB = readMux(readSelB, regs);
  assign readC = readMux(readSelC, regs);

endmodule

`default_nettype wire

// ==== src/operandIssue.sv ====
// ==========================================================================
// ID/EX stage
// latches operands of a decoded item and offers them four-phase
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module operandIssue (
  input  logic clk,
  input  logic clr,
  input  logic full,
  input  regFilePkg::decodedInstr_t decoded,
  output logic take,
  output regFilePkg::regAddr_t readSelA,
  output regFilePkg::regAddr_t readSelB,
  output regFilePkg::regAddr_t readSelC,
  input  regFilePkg::word_t readA,
  input  regFilePkg::word_t readB,
  input  regFilePkg::word_t readC,
  output logic issueReq,
  input  logic issueAck,
  output regFilePkg::operandBundle_t issueBundle
);

  import regFilePkg::*;

  // stage holds an item until the outbound exchange completes
  logic busy;

  // selects follow the decoder's held item
  assign readSelA = decoded.rn;
  assign readSelB = decoded.rm;
  assign readSelC = decoded.rd;

  // single-cycle pull from the decoder
  assign take = full && !busy;

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      busy <= 1'b0;
      issueReq <= 1'b0;
      issueBundle <= '0;
    end
    else if (take)
    begin
      busy <= 1'b1;
      issueReq <= 1'b1;
      // control fields straight through
      issueBundle.cond <= decoded.cond;
      issueBundle.opcode <= decoded.opcode;
      issueBundle.isBranch <= decoded.isBranch;
      issueBundle.link <= decoded.link;
      issueBundle.rd <= decoded.rd;
      issueBundle.imm <= decoded.imm;
      // operands as read before this edge
      issueBundle.opA <= readA;
      issueBundle.opB <= readB;
      issueBundle.opC <= readC;
    end
    else if (issueReq && issueAck)
    begin
      // ack seen, withdraw request
      issueReq <= 1'b0;
    end
    else if (busy && !issueReq && !issueAck)
    begin
      // ack dropped, exchange over
      busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/regFileTop.sv ====
// ==========================================================================
// register file pipeline top
// IF/ID stage, register file and ID/EX stage wired together
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module regFileTop (
  input  logic clk,
  input  logic clr,
  input  logic instrReq,
  input  regFilePkg::instrWord_u instrWord,
  output logic instrAck,
  input  regFilePkg::regWrite_t regWrite,
  output logic issueReq,
  input  logic issueAck,
  output regFilePkg::operandBundle_t issueBundle
);

  import regFilePkg::*;

  // decoder to issue stage
  logic take;
  logic full;
  decodedInstr_t decoded;

  // fetch step into R15
  logic pcAdvance;

  // issue stage to register file
  regAddr_t readSelA;
  regAddr_t readSelB;
  regAddr_t readSelC;
  word_t readA;
  word_t readB;
  word_t readC;

  instrDecoder i_instrDecoder (
    .clk(clk),
    .clr(clr),
    .instrReq(instrReq),
    .instrWord(instrWord),
    .instrAck(instrAck),
    .take(take),
    .full(full),
    .decoded(decoded),
    .pcAdvance(pcAdvance)
  );

  registerFile i_registerFile (
    .clk(clk),
    .clr(clr),
    .regWrite(regWrite),
    .pcAdvance(pcAdvance),
    .readSelA(readSelA),
    .readSelB(readSelB),
    .readSelC(readSelC),
    .readA(readA),
    .readB(readB),
    .readC(readC)
  );

  operandIssue i_operandIssue (
    .clk(clk),
    .clr(clr),
    .full(full),
    .decoded(decoded),
    .take(take),
    .readSelA(readSelA),
    .readSelB(readSelB),
    .readSelC(readSelC),
    .readA(readA),
    .readB(readB),
    .readC(readC),
    .issueReq(issueReq),
    .issueAck(issueAck),
    .issueBundle(issueBundle)
  );

endmodule

`default_nettype wire

// ==== verification/regFileAssertions.sv ====
// ==========================================================================
// handshake checks for the register file pipeline top
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module regFileAssertions (
  input logic clk,
  input logic clr,
  input logic instrReq,
  input logic instrAck,
  input logic issueReq,
  input logic issueAck,
  input regFilePkg::operandBundle_t issueBundle
);

  // ack only answers a pending request
  ackAfterReq: assert property (@(posedge clk) disable iff (!clr)
    $rose(instrAck) |-> $past(instrReq))
    else $error("instrAck rose without instrReq");

  // offer held, payload frozen
  issueHeld: assert property (@(posedge clk) disable iff (!clr)
    issueReq && !issueAck |=> issueReq && $stable(issueBundle))
    else $error("issueReq or issueBundle changed before issueAck");

  // new offer only once the old ack is gone
  issueRestart: assert property (@(posedge clk) disable iff (!clr)
    $rose(issueReq) |-> !$past(issueAck))
    else $error("issueReq rose again while issueAck was still high");

endmodule

`default_nettype wire

// ==== verification/regFileTb.sv ====
// ==========================================================================
// register file pipeline testbench
// directed tests over both handshakes, register writes, PC step and stall
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module regFileTb;

  import regFilePkg::*;

  // roughly 300 cycles of tests, three times over
  localparam int cycleLimit = 900;

  logic clk;
  logic clr;
  logic instrReq;
  instrWord_u instrWord;
  logic instrAck;
  regWrite_t regWrite;
  logic issueReq;
  logic issueAck;
  operandBundle_t issueBundle;

  // expected register contents, R15 is the PC
  word_t regModel [regCount];
  logic [31:0] lfsr;
  int accepted = 0;
  int cycles = 0;
  int checkCount = 0;
  int errorCount = 0;
  int errorsBefore = 0;

  regFileTop i_dut (
    .clk(clk),
    .clr(clr),
    .instrReq(instrReq),
    .instrWord(instrWord),
    .instrAck(instrAck),
    .regWrite(regWrite),
    .issueReq(issueReq),
    .issueAck(issueAck),
    .issueBundle(issueBundle)
  );

  bind regFileTop regFileAssertions i_assertions (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: tests did not finish within %0d cycles", cycleLimit);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic checkValue(input string name, input word_t expected, input word_t actual);
    checkCount++;
    if (expected !== actual)
    begin
      errorCount++;
      $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // Fibonacci step, taps 32 22 2 1
  function automatic logic shiftLfsr();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic word_t randomBits(input int n);
    word_t value;
    value = '0;
    for (int i = 0; i < n; i++)
      value = {value[30:0], shiftLfsr()};
    return value;
  endfunction

  function automatic instrWord_u makeDp(input logic [3:0] cond, input logic [3:0] opcode,
      input regAddr_t rn, input regAddr_t rm, input regAddr_t rd, input logic [7:0] shiftHigh);
    instrWord_u w;
    w = '0;
    w.dp.cond = cond;
    w.dp.opcode = opcode;
    w.dp.rn = rn;
    w.dp.rd = rd;
    w.dp.shifterOp = {shiftHigh, rm};
    return w;
  endfunction

  // operands from the model, taken after the instruction's own PC step
  function automatic operandBundle_t expectDp(input instrWord_u w);
    operandBundle_t e;
    e = '0;
    e.cond = w.dp.cond;
    e.opcode = w.dp.opcode;
    e.rd = w.dp.rd;
    e.opA = regModel[w.dp.rn];
    e.opB = regModel[w.dp.shifterOp[3:0]];
    e.opC = regModel[w.dp.rd];
    e.imm = {20'b0, w.dp.shifterOp};
    return e;
  endfunction

  task automatic writeReg(input regAddr_t addr, input word_t data);
    regWrite.en = 1'b1;
    regWrite.addr = addr;
    regWrite.data = data;
    @(negedge clk);
    regWrite.en = 1'b0;
    regModel[addr] = data;
  endtask

  task automatic sendInstr(input instrWord_u w);
    instrWord = w;
    instrReq = 1'b1;
    @(negedge clk);
    while (!instrAck)
      @(negedge clk);
    accepted++;
    regModel[pcIndex] = regModel[pcIndex] + word_t'(pcStep);
    instrReq = 1'b0;
    while (instrAck)
      @(negedge clk);
  endtask

  // branches leave opcode, rd, opB and opC undefined by the format
  task automatic receiveIssue(input operandBundle_t e, input bit isBr, input int hold);
    while (!issueReq)
      @(negedge clk);
    checkValue("issueBundle.cond", word_t'(e.cond), word_t'(issueBundle.cond));
    checkValue("issueBundle.isBranch", word_t'(isBr), word_t'(issueBundle.isBranch));
    checkValue("issueBundle.link", word_t'(e.link), word_t'(issueBundle.link));
    checkValue("issueBundle.opA", e.opA, issueBundle.opA);
    checkValue("issueBundle.imm", e.imm, issueBundle.imm);
    if (!isBr)
    begin
      checkValue("issueBundle.opcode", word_t'(e.opcode), word_t'(issueBundle.opcode));
      checkValue("issueBundle.rd", word_t'(e.rd), word_t'(issueBundle.rd));
      checkValue("issueBundle.opB", e.opB, issueBundle.opB);
      checkValue("issueBundle.opC", e.opC, issueBundle.opC);
    end
    repeat (hold)
      @(negedge clk);
    issueAck = 1'b1;
    @(negedge clk);
    while (issueReq)
      @(negedge clk);
    // ack lingers past the drop of issueReq, stage must stay full
    repeat (hold)
      @(negedge clk);
    issueAck = 1'b0;
  endtask

  task automatic reportTest(input string name);
    $display("%s: %0d mismatches", name, errorCount - errorsBefore);
    errorsBefore = errorCount;
  endtask

  task automatic testResetState();
    instrWord_u w;
    checkValue("instrAck", '0, word_t'(instrAck));
    checkValue("issueReq", '0, word_t'(issueReq));
    // reads R3, R7 and R12
    w = makeDp(4'he, 4'h9, 4'd3, 4'd7, 4'd12, 8'ha5);
    sendInstr(w);
    receiveIssue(expectDp(w), 1'b0, 0);
    reportTest("reset state");
  endtask

  task automatic testWriteRead();
    instrWord_u w;
    for (int i = 0; i < pcIndex; i++)
      writeReg(regAddr_t'(i), randomBits(32));
    // rn, rm and rd each sweep all sixteen registers
    for (int i = 0; i < regCount; i++)
    begin
      w = makeDp(4'(randomBits(4)), 4'(randomBits(4)), regAddr_t'(i), regAddr_t'(i + 5),
          regAddr_t'(i + 11), 8'(randomBits(8)));
      sendInstr(w);
      receiveIssue(expectDp(w), 1'b0, i % 3);
    end
    reportTest("write and read");
  endtask

  task automatic testBranchDecode();
    instrWord_u w;
    operandBundle_t e;
    for (int i = 0; i < 2; i++)
    begin
      w = '0;
      w.br.cond = 4'(randomBits(4));
      w.br.instrClass = branchClass;
      w.br.link = (i == 0);
      // positive offset first, then negative
      w.br.offset = {i == 1, 23'(randomBits(23))};
      sendInstr(w);
      e = '0;
      e.cond = w.br.cond;
      e.link = w.br.link;
      e.opA = word_t'(pcStep * accepted);
      e.imm = word_t'(int'(signed'(w.br.offset)) * 4);
      receiveIssue(e, 1'b1, 2);
    end
    reportTest("PC advance and branch decode");
  endtask

  task automatic testPcWrite();
    word_t v;
    instrWord_u w;
    operandBundle_t e;
    v = randomBits(32);
    writeReg(regAddr_t'(pcIndex), v);
    w = makeDp(4'h1, 4'h4, regAddr_t'(pcIndex), 4'd2, 4'd6, 8'h3c);
    sendInstr(w);
    e = expectDp(w);
    e.opA = v + word_t'(pcStep);
    receiveIssue(e, 1'b0, 0);
    reportTest("R15 write precedence");
  endtask

  task automatic testBackPressure();
    instrWord_u w1;
    instrWord_u w2;
    instrWord_u w3;
    operandBundle_t e1;
    operandBundle_t e2;
    w1 = makeDp(4'h2, 4'h1, 4'd1, 4'd2, 4'd3, 8'h11);
    w2 = makeDp(4'h3, 4'h2, 4'd4, 4'd5, 4'd6, 8'h22);
    w3 = makeDp(4'h4, 4'h3, 4'd7, 4'd8, 4'd9, 8'h33);
    sendInstr(w1);
    e1 = expectDp(w1);
    // decoder holds the second while the first waits at issue
    sendInstr(w2);
    e2 = expectDp(w2);
    instrWord = w3;
    instrReq = 1'b1;
    repeat (20)
    begin
      @(negedge clk);
      checkValue("instrAck", '0, word_t'(instrAck));
      checkValue("issueReq", 32'd1, word_t'(issueReq));
    end
    receiveIssue(e1, 1'b0, 0);
    while (!instrAck)
      @(negedge clk);
    accepted++;
    regModel[pcIndex] = regModel[pcIndex] + word_t'(pcStep);
    instrReq = 1'b0;
    while (instrAck)
      @(negedge clk);
    receiveIssue(e2, 1'b0, 0);
    receiveIssue(expectDp(w3), 1'b0, 0);
    reportTest("back-pressure");
  endtask

  initial
  begin
    clr = 1'b0;
    instrReq = 1'b0;
    instrWord = '0;
    regWrite = '0;
    issueAck = 1'b0;
    lfsr = 32'h36b3_0b5d;
    for (int i = 0; i < regCount; i++)
      regModel[i] = '0;
    repeat (10)
      @(negedge clk);
    clr = 1'b1;
    @(negedge clk);
    testResetState();
    testWriteRead();
    testBranchDecode();
    testPcWrite();
    testBackPressure();
    $display("checks: %0d, mismatches: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
src/regFilePkg.sv
src/instrDecoder.sv
src/registerFile.sv
src/operandIssue.sv
src/regFileTop.sv
verification/regFileAssertions.sv
verification/regFileTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the register file regression with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module regFileTb -f sources.f -o regFileSim \
  && ./obj_dir/regFileSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && exit 0 || exit 1
